//--- arbiter/arbiter_request_memory.sv
/*
 * Round-robin N-to-1 arbiter in front of a show-ahead request FIFO.
 * Lanes hold req_valid until granted; the FIFO head is popped by memory.
 */

module arbiter_request_memory (
    input  logic                                 ap_clk,
    input  logic                                 areset_lanes,
    input  logic [bundle_cfg_pkg::NUM_LANES-1:0] req_valid,
    input  packet_pkg::addr_t                    req_addr [bundle_cfg_pkg::NUM_LANES-1:0],
    input  logic                                 mem_req_rd_en,
    output logic [bundle_cfg_pkg::NUM_LANES-1:0] grant,
    output logic                                 mem_req_valid,
    output packet_pkg::addr_t                    mem_req_addr,
    output packet_pkg::lane_id_t                 mem_req_lane_id,
    output logic                                 fifo_empty
);

    // FIFO storage, address and originating lane per entry
    packet_pkg::addr_t    addr_mem [bundle_cfg_pkg::REQ_FIFO_DEPTH];
    packet_pkg::lane_id_t id_mem   [bundle_cfg_pkg::REQ_FIFO_DEPTH];

    bundle_cfg_pkg::fifo_ptr_t wr_ptr;
    bundle_cfg_pkg::fifo_ptr_t rd_ptr;
    bundle_cfg_pkg::fifo_cnt_t fifo_count;

    packet_pkg::lane_id_t last_grant;
    packet_pkg::lane_id_t grant_idx;
    logic                 grant_any;
    logic                 push;
    logic                 pop;

    // --------------------
    // Round-robin pick
    // --------------------
    // Search starts one past the last granted lane
    always_comb begin
        int idx;
        grant_any = 1'b0;
        grant_idx = '0;
        for (int k = 1; k <= bundle_cfg_pkg::NUM_LANES; k++) begin
            idx = (int'(last_grant) + k) % bundle_cfg_pkg::NUM_LANES;
            if (!grant_any && req_valid[idx]) begin
                grant_any = 1'b1;
                grant_idx = packet_pkg::lane_id_t'(idx);
            end
        end
    end

    // No grant once the FIFO reaches its threshold
    assign push = grant_any &&
                  (fifo_count < bundle_cfg_pkg::fifo_cnt_t'(bundle_cfg_pkg::REQ_FIFO_PROG_FULL));

    // Pop while empty is ignored
    assign pop = mem_req_rd_en && (fifo_count != '0);

    // One-cycle grant to the chosen lane only
    always_comb begin
        for (int k = 0; k < bundle_cfg_pkg::NUM_LANES; k++) begin
            grant[k] = push && (grant_idx == packet_pkg::lane_id_t'(k));
        end
    end

    // --------------------
    // FIFO
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (push) begin
            addr_mem[wr_ptr] <= req_addr[grant_idx];
            id_mem[wr_ptr]   <= grant_idx;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_lanes) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_count <= '0;
            // Lane 0 wins the first round
            last_grant <= packet_pkg::lane_id_t'(bundle_cfg_pkg::NUM_LANES - 1);
        end else begin
            if (push) begin
                last_grant <= grant_idx;
                wr_ptr <= (wr_ptr == bundle_cfg_pkg::fifo_ptr_t'(bundle_cfg_pkg::REQ_FIFO_DEPTH - 1))
                          ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == bundle_cfg_pkg::fifo_ptr_t'(bundle_cfg_pkg::REQ_FIFO_DEPTH - 1))
                          ? '0 : rd_ptr + 1'b1;
            end
            // Occupancy holds when push and pop coincide
            case ({push, pop})
                2'b10:   fifo_count <= fifo_count + 1'b1;
                2'b01:   fifo_count <= fifo_count - 1'b1;
                default: fifo_count <= fifo_count;
            endcase
        end
    end

    // Show-ahead head of the FIFO
    assign mem_req_valid   = (fifo_count != '0);
    assign fifo_empty      = (fifo_count == '0);
    assign mem_req_addr    = addr_mem[rd_ptr];
    assign mem_req_lane_id = id_mem[rd_ptr];

endmodule : arbiter_request_memory

//--- arbiter/arbiter_response_memory.sv
/*
 * 1-to-N response distributor. Routes each memory response to the lane named
 * by its id through one register stage; the data word is shared by all lanes.
 */

module arbiter_response_memory (
    input  logic                                 ap_clk,
    input  logic                                 areset_lanes,
    input  logic                                 resp_in_valid,
    input  packet_pkg::lane_id_t                 resp_in_lane_id,
    input  packet_pkg::data_t                    resp_in_data,
    output logic [bundle_cfg_pkg::NUM_LANES-1:0] resp_valid,
    output packet_pkg::data_t                    resp_data
);

    // --------------------
    // Lane select
    // --------------------
    // One-hot valid, at most one lane per cycle
    always_ff @(posedge ap_clk) begin
        if (areset_lanes) begin
            resp_valid <= '0;
        end else begin
            for (int k = 0; k < bundle_cfg_pkg::NUM_LANES; k++) begin
                resp_valid[k] <= resp_in_valid &&
                                 (resp_in_lane_id == packet_pkg::lane_id_t'(k));
            end
        end
    end

    // Data word for whichever lane is selected
    always_ff @(posedge ap_clk) begin
        resp_data <= resp_in_data;
    end

endmodule : arbiter_response_memory

//--- common/bundle_cfg_pkg.sv
/*
 * Configuration of the lane bundle: lane count and request FIFO sizing.
 * Referenced by scoped names from the top level and the request arbiter.
 */

package bundle_cfg_pkg;

    // --------------------
    // Lane count
    // --------------------
    // Number of memory-reading lanes behind one descriptor
    localparam int NUM_LANES = 4;

    // --------------------
    // Request FIFO
    // --------------------
    // Entries in the memory-facing request FIFO
    localparam int REQ_FIFO_DEPTH = 8;
    // Occupancy at which the arbiter stops granting
    localparam int REQ_FIFO_PROG_FULL = 6;

    // Pointer and occupancy widths follow from the depth
    localparam int REQ_FIFO_PTR_W = $clog2(REQ_FIFO_DEPTH);
    localparam int REQ_FIFO_CNT_W = $clog2(REQ_FIFO_DEPTH + 1);

    // Read/write pointer into the FIFO storage
    typedef logic [REQ_FIFO_PTR_W-1:0] fifo_ptr_t;
    // Number of entries held, 0 up to REQ_FIFO_DEPTH
    typedef logic [REQ_FIFO_CNT_W-1:0] fifo_cnt_t;

endpackage : bundle_cfg_pkg

//--- common/packet_pkg.sv
/*
 * Field types of the descriptor and of the memory request/response packets,
 * plus the lane state encoding. Referenced by scoped names only.
 */

package packet_pkg;

    // --------------------
    // Packet fields
    // --------------------
    // Index of a lane, also carried in requests and responses
    typedef logic [$clog2(bundle_cfg_pkg::NUM_LANES)-1:0] lane_id_t;

    // Word address sent to memory
    typedef logic [31:0] addr_t;

    // Data word returned by memory
    typedef logic [31:0] data_t;

    // --------------------
    // Descriptor and lane
    // --------------------
    // Requests issued by each lane for one descriptor
    typedef logic [7:0] count_t;

    // Per-lane accumulator, wide enough for 255 full words
    typedef logic [39:0] sum_t;

    // Lane progress through one descriptor
    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        WAIT,
        FINISHED
    } lane_state_t;

endpackage : packet_pkg

//--- hdl/bundle_lanes.sv
/*
 * Top level of the lane bundle. One descriptor fans out to every lane, lane
 * reads merge into one request FIFO, and responses return by lane id.
 * done_out goes high once all lanes have finished and the FIFO has drained.
 */

module bundle_lanes (
    input  logic                ap_clk,
    input  logic                areset_lanes,
    input  logic                descriptor_valid,
    input  packet_pkg::addr_t   descriptor_base,
    input  packet_pkg::count_t  descriptor_count,
    input  logic                mem_req_rd_en,
    input  logic                mem_resp_valid,
    input  packet_pkg::lane_id_t mem_resp_lane_id,
    input  packet_pkg::data_t   mem_resp_data,
    output logic                mem_req_valid,
    output packet_pkg::addr_t   mem_req_addr,
    output packet_pkg::lane_id_t mem_req_lane_id,
    output packet_pkg::sum_t    lane_sum [bundle_cfg_pkg::NUM_LANES-1:0],
    output logic                done_out
);

    // --------------------
    // Input registers
    // --------------------
    logic                 desc_valid_reg;
    packet_pkg::addr_t    desc_base_reg;
    packet_pkg::count_t   desc_count_reg;
    logic                 resp_valid_reg;
    packet_pkg::lane_id_t resp_lane_id_reg;
    packet_pkg::data_t    resp_data_reg;

    // Lane side of the arbiter and distributor
    logic [bundle_cfg_pkg::NUM_LANES-1:0] lane_req_valid;
    packet_pkg::addr_t                    lane_req_addr [bundle_cfg_pkg::NUM_LANES-1:0];
    logic [bundle_cfg_pkg::NUM_LANES-1:0] lane_grant;
    logic [bundle_cfg_pkg::NUM_LANES-1:0] lane_resp_valid;
    packet_pkg::data_t                    lane_resp_data;
    logic [bundle_cfg_pkg::NUM_LANES-1:0] lane_done;
    logic                                 fifo_empty;

    // Descriptor and response strobes
    always_ff @(posedge ap_clk) begin
        if (areset_lanes) begin
            desc_valid_reg <= 1'b0;
            resp_valid_reg <= 1'b0;
        end else begin
            desc_valid_reg <= descriptor_valid;
            resp_valid_reg <= mem_resp_valid;
        end
    end

    // Descriptor fields stay put for the whole run
    always_ff @(posedge ap_clk) begin
        if (descriptor_valid) begin
            desc_base_reg  <= descriptor_base;
            desc_count_reg <= descriptor_count;
        end
        resp_lane_id_reg <= mem_resp_lane_id;
        resp_data_reg    <= mem_resp_data;
    end

    // --------------------
    // Done
    // --------------------
    // Forced low on the descriptor and the start cycle, while lanes still
    // show the FINISHED state of the previous run
    always_ff @(posedge ap_clk) begin
        if (areset_lanes) begin
            done_out <= 1'b0;
        end else begin
            done_out <= (&lane_done) & fifo_empty & ~descriptor_valid & ~desc_valid_reg;
        end
    end

    // --------------------
    // Lanes
    // --------------------
    for (genvar i = 0; i < bundle_cfg_pkg::NUM_LANES; i++) begin : g_lane
        lane_reader #(
            .LANE_ID(i)
        ) u_lane_reader (
            .ap_clk      (ap_clk),
            .areset_lanes(areset_lanes),
            .start       (desc_valid_reg),
            .base        (desc_base_reg),
            .count       (desc_count_reg),
            .grant       (lane_grant[i]),
            .resp_valid  (lane_resp_valid[i]),
            .resp_data   (lane_resp_data),
            .req_valid   (lane_req_valid[i]),
            .req_addr    (lane_req_addr[i]),
            .sum         (lane_sum[i]),
            .done        (lane_done[i])
        );
    end

    // N-to-1 toward memory
    arbiter_request_memory u_arbiter_request_memory (
        .ap_clk         (ap_clk),
        .areset_lanes   (areset_lanes),
        .req_valid      (lane_req_valid),
        .req_addr       (lane_req_addr),
        .mem_req_rd_en  (mem_req_rd_en),
        .grant          (lane_grant),
        .mem_req_valid  (mem_req_valid),
        .mem_req_addr   (mem_req_addr),
        .mem_req_lane_id(mem_req_lane_id),
        .fifo_empty     (fifo_empty)
    );

    // 1-to-N back to the lanes
    arbiter_response_memory u_arbiter_response_memory (
        .ap_clk         (ap_clk),
        .areset_lanes   (areset_lanes),
        .resp_in_valid  (resp_valid_reg),
        .resp_in_lane_id(resp_lane_id_reg),
        .resp_in_data   (resp_data_reg),
        .resp_valid     (lane_resp_valid),
        .resp_data      (lane_resp_data)
    );

endmodule : bundle_lanes

//--- hdl/lane_reader.sv
/*
 * One reading lane. On start it requests base + k*NUM_LANES + LANE_ID for
 * k = 0 .. count-1, sums the returned words and reports done when every
 * response is back.
 */

module lane_reader #(
    parameter int LANE_ID = 0
) (
    input  logic               ap_clk,
    input  logic               areset_lanes,
    input  logic               start,
    input  packet_pkg::addr_t  base,
    input  packet_pkg::count_t count,
    input  logic               grant,
    input  logic               resp_valid,
    input  packet_pkg::data_t  resp_data,
    output logic               req_valid,
    output packet_pkg::addr_t  req_addr,
    output packet_pkg::sum_t   sum,
    output logic               done
);

    packet_pkg::lane_state_t state;
    // Requests granted so far
    packet_pkg::count_t      issued;
    // Responses returned so far
    packet_pkg::count_t      received;

    // --------------------
    // Lane FSM
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_lanes) begin
            state    <= packet_pkg::IDLE;
            issued   <= '0;
            received <= '0;
            sum      <= '0;
        end else if (start) begin
            // A new descriptor restarts the lane from any state
            issued   <= '0;
            received <= '0;
            sum      <= '0;
            state    <= (count == '0) ? packet_pkg::FINISHED : packet_pkg::ISSUE;
        end else begin
            // Responses may already arrive while later requests are issued
            if (resp_valid) begin
                sum      <= sum + packet_pkg::sum_t'(resp_data);
                received <= received + 1'b1;
            end
            case (state)
                packet_pkg::ISSUE: begin
                    if (grant) begin
                        issued <= issued + 1'b1;
                        if (issued == packet_pkg::count_t'(count - 1'b1)) begin
                            state <= packet_pkg::WAIT;
                        end
                    end
                end
                packet_pkg::WAIT: begin
                    // Last response closes the run
                    if (resp_valid && (received == packet_pkg::count_t'(count - 1'b1))) begin
                        state <= packet_pkg::FINISHED;
                    end
                end
                default: state <= state;
            endcase
        end
    end

    // Next interleaved address, stepping by the lane count per grant
    always_ff @(posedge ap_clk) begin
        if (start) begin
            req_addr <= base + packet_pkg::addr_t'(LANE_ID);
        end else if (grant) begin
            req_addr <= req_addr + packet_pkg::addr_t'(bundle_cfg_pkg::NUM_LANES);
        end
    end

    // Request held as a level until the last grant
    assign req_valid = (state == packet_pkg::ISSUE);
    assign done      = (state == packet_pkg::FINISHED);

endmodule : lane_reader

//--- run_sim.sh
#!/usr/bin/env bash
# Compile the lane bundle testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing -Wno-fatal \
    --top-module tb_bundle_lanes \
    -Mdir "$build_dir" \
    -f src.f
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

"$build_dir/Vtb_bundle_lanes" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

# Pass only when the testbench printed its pass line
if grep -qx "No errors" "$log_file"; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed"
exit 1

//--- src.f
common/bundle_cfg_pkg.sv
common/packet_pkg.sv
arbiter/arbiter_request_memory.sv
arbiter/arbiter_response_memory.sv
hdl/lane_reader.sv
hdl/bundle_lanes.sv
testbench/tb_bundle_lanes.sv

//--- testbench/tb_bundle_lanes.sv
/*
 * Directed testbench for the lane bundle. A behavioral memory pops requests,
 * returns address-derived data and records which addresses were requested.
 * Each test task runs descriptors and checks sums, request set and done_out.
 */

module tb_bundle_lanes;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int LANES        = bundle_cfg_pkg::NUM_LANES;
    localparam int RESET_CYCLES = 16;
    localparam int MAX_REQ      = 256;
    // Requests per lane for each descriptor run
    localparam int CNT_SINGLE  = 6;
    localparam int CNT_SET     = 8;
    localparam int CNT_BP      = 10;
    localparam int CNT_SHUFFLE = 7;
    localparam int CNT_FIRST   = 4;
    localparam int CNT_SECOND  = 5;
    localparam int TOTAL_REQ   = LANES * (CNT_SINGLE + CNT_SET + CNT_BP + CNT_SHUFFLE
                                          + CNT_FIRST + CNT_SECOND);
    // Reset, then 200 cycles per budget (reset check and six runs) plus 20 per request
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 7 * 200 + 20 * TOTAL_REQ;

    logic                 ap_clk = 1'b0;
    logic                 areset_lanes;
    logic                 descriptor_valid;
    packet_pkg::addr_t    descriptor_base;
    packet_pkg::count_t   descriptor_count;
    logic                 mem_req_rd_en = 1'b0;
    logic                 mem_resp_valid = 1'b0;
    packet_pkg::lane_id_t mem_resp_lane_id = '0;
    packet_pkg::data_t    mem_resp_data = '0;
    logic                 mem_req_valid;
    packet_pkg::addr_t    mem_req_addr;
    packet_pkg::lane_id_t mem_req_lane_id;
    packet_pkg::sum_t     lane_sum [LANES-1:0];
    logic                 done_out;

    // --------------------
    // Test and memory state
    // --------------------
    integer               seed = 32'h5cff_e57e;
    string                cur_test = "";
    int                   error_count = 0;
    int                   tests_run = 0;
    int                   tests_failed = 0;
    // Pop one in pop_every cycles, respond 1..resp_delay_max cycles later
    int                   pop_every = 1;
    int                   resp_delay_max = 1;
    bit                   resp_shuffle = 1'b0;
    packet_pkg::addr_t    run_base = '0;
    int                   run_count = 0;
    int                   hit_count [MAX_REQ];
    // Entries granted into the request FIFO and not yet popped
    int                   outstanding = 0;
    int                   cycle_no = 0;
    packet_pkg::data_t    rq_data [$];
    packet_pkg::lane_id_t rq_lane [$];
    int                   rq_due [$];
    int                   ready_idx [$];

    always #2 ap_clk = ~ap_clk;

    bundle_lanes u_bundle_lanes (
        .ap_clk          (ap_clk),
        .areset_lanes    (areset_lanes),
        .descriptor_valid(descriptor_valid),
        .descriptor_base (descriptor_base),
        .descriptor_count(descriptor_count),
        .mem_req_rd_en   (mem_req_rd_en),
        .mem_resp_valid  (mem_resp_valid),
        .mem_resp_lane_id(mem_resp_lane_id),
        .mem_resp_data   (mem_resp_data),
        .mem_req_valid   (mem_req_valid),
        .mem_req_addr    (mem_req_addr),
        .mem_req_lane_id (mem_req_lane_id),
        .lane_sum        (lane_sum),
        .done_out        (done_out)
    );

    // Word the memory returns for an address
    function automatic packet_pkg::data_t mem_word(packet_pkg::addr_t addr);
        return addr ^ 32'hA5A5_0000;
    endfunction

    // Sum over one lane's interleaved addresses
    function automatic packet_pkg::sum_t expected_sum(packet_pkg::addr_t base, int count,
                                                      int lane);
        packet_pkg::sum_t acc;
        acc = '0;
        for (int k = 0; k < count; k++) begin
            acc = acc + packet_pkg::sum_t'(mem_word(base + packet_pkg::addr_t'(k * LANES + lane)));
        end
        return acc;
    endfunction

    task automatic report_mismatch(string what, logic [63:0] expected, logic [63:0] actual);
        error_count++;
        $display("[ERROR] %s: %s expected %0h actual %0h", cur_test, what, expected, actual);
    endtask

    task automatic report_failure(string what);
        error_count++;
        $display("[ERROR] %s: %s", cur_test, what);
    endtask

    // --------------------
    // Memory model
    // --------------------
    always @(negedge ap_clk) begin
        int offset;
        int pick;
        cycle_no++;
        // Grants seen now are written into the FIFO on the next edge
        if (!areset_lanes) begin
            outstanding += $countones(u_bundle_lanes.lane_grant);
        end
        mem_req_rd_en = 1'b0;
        if (!areset_lanes && mem_req_valid &&
            (pop_every <= 1 || ({$random(seed)} % pop_every) == 0)) begin
            mem_req_rd_en = 1'b1;
            outstanding--;
            offset = int'(mem_req_addr - run_base);
            if (offset < 0 || offset >= LANES * run_count) begin
                report_failure($sformatf("request to address %0h outside the run", mem_req_addr));
            end else begin
                hit_count[offset]++;
                if (mem_req_lane_id != packet_pkg::lane_id_t'(offset % LANES)) begin
                    report_mismatch("request lane id", offset % LANES, mem_req_lane_id);
                end
            end
            rq_data.push_back(mem_word(mem_req_addr));
            rq_lane.push_back(mem_req_lane_id);
            if (resp_delay_max <= 1) begin
                rq_due.push_back(cycle_no + 1);
            end else begin
                rq_due.push_back(cycle_no + 1 + int'({$random(seed)} % resp_delay_max));
            end
        end
        if (outstanding > bundle_cfg_pkg::REQ_FIFO_DEPTH) begin
            report_failure($sformatf("%0d requests held in the FIFO", outstanding));
        end
        // One response per cycle, the oldest due one or a random due one
        mem_resp_valid = 1'b0;
        ready_idx.delete();
        for (int i = 0; i < rq_due.size(); i++) begin
            if (rq_due[i] <= cycle_no) begin
                ready_idx.push_back(i);
            end
        end
        if (ready_idx.size() > 0) begin
            pick = resp_shuffle ? ready_idx[{$random(seed)} % ready_idx.size()] : ready_idx[0];
            mem_resp_valid   = 1'b1;
            mem_resp_lane_id = rq_lane[pick];
            mem_resp_data    = rq_data[pick];
            rq_data.delete(pick);
            rq_lane.delete(pick);
            rq_due.delete(pick);
        end
    end

    // --------------------
    // Test helpers
    // --------------------
    task automatic set_memory(int pop_n, int delay_max, bit shuffle);
        pop_every      = pop_n;
        resp_delay_max = delay_max;
        resp_shuffle   = shuffle;
    endtask

    task automatic finish_test(int errs_before);
        tests_run++;
        if (error_count == errs_before) begin
            $display("PASS %s", cur_test);
        end else begin
            tests_failed++;
            $display("FAIL %s, %0d errors", cur_test, error_count - errs_before);
        end
    endtask

    // Send one descriptor and wait for done_out, sums optionally checked clear
    task automatic run_descriptor(packet_pkg::addr_t base, int count, bit check_clear);
        int budget;
        int cycles;
        budget    = 200 + 20 * LANES * count;
        run_base  = base;
        run_count = count;
        for (int i = 0; i < MAX_REQ; i++) begin
            hit_count[i] = 0;
        end
        @(negedge ap_clk);
        descriptor_valid = 1'b1;
        descriptor_base  = base;
        descriptor_count = packet_pkg::count_t'(count);
        @(negedge ap_clk);
        descriptor_valid = 1'b0;
        if (done_out !== 1'b0) begin
            report_mismatch("done_out after descriptor", 0, done_out);
        end
        cycles = 0;
        while (done_out !== 1'b1 && cycles < budget) begin
            @(negedge ap_clk);
            cycles++;
            // Lanes restarted one edge ago, no new response can have landed
            if (check_clear && cycles == 1) begin
                for (int i = 0; i < LANES; i++) begin
                    if (lane_sum[i] !== '0) begin
                        report_mismatch($sformatf("lane %0d sum after restart", i), 0,
                                        lane_sum[i]);
                    end
                end
            end
        end
        if (done_out !== 1'b1) begin
            report_failure($sformatf("done_out did not rise within %0d cycles", budget));
        end else if (rq_due.size() != 0 || mem_req_valid !== 1'b0) begin
            report_failure("done_out rose while requests or responses were pending");
        end
    endtask

    task automatic verify_lane_sums(packet_pkg::addr_t base, int count);
        packet_pkg::sum_t exp;
        for (int i = 0; i < LANES; i++) begin
            exp = expected_sum(base, count, i);
            if (lane_sum[i] !== exp) begin
                report_mismatch($sformatf("lane %0d sum", i), exp, lane_sum[i]);
            end
        end
    endtask

    // Every address of the run requested exactly once
    task automatic verify_request_set(int count);
        for (int o = 0; o < LANES * count; o++) begin
            if (hit_count[o] != 1) begin
                report_mismatch($sformatf("requests to address %0h", run_base + o), 1,
                                hit_count[o]);
            end
        end
    endtask

    // --------------------
    // Tests
    // --------------------
    task automatic check_reset_values();
        int errs;
        cur_test = "reset_values";
        errs = error_count;
        if (done_out !== 1'b0) begin
            report_mismatch("done_out", 0, done_out);
        end
        if (mem_req_valid !== 1'b0) begin
            report_mismatch("mem_req_valid", 0, mem_req_valid);
        end
        for (int i = 0; i < LANES; i++) begin
            if (lane_sum[i] !== '0) begin
                report_mismatch($sformatf("lane %0d sum", i), 0, lane_sum[i]);
            end
        end
        finish_test(errs);
    endtask

    task automatic test_single_descriptor();
        int errs;
        cur_test = "single_descriptor";
        errs = error_count;
        set_memory(1, 1, 1'b0);
        run_descriptor(32'h0000_0100, CNT_SINGLE, 1'b0);
        verify_lane_sums(32'h0000_0100, CNT_SINGLE);
        finish_test(errs);
    endtask

    task automatic test_request_set();
        int errs;
        cur_test = "request_set";
        errs = error_count;
        set_memory(1, 1, 1'b0);
        run_descriptor(32'h0000_2000, CNT_SET, 1'b0);
        verify_request_set(CNT_SET);
        finish_test(errs);
    endtask

    // Rare pops fill the FIFO to its threshold
    task automatic test_back_pressure();
        int errs;
        cur_test = "back_pressure";
        errs = error_count;
        set_memory(8, 1, 1'b0);
        run_descriptor(32'h3000_0010, CNT_BP, 1'b0);
        verify_lane_sums(32'h3000_0010, CNT_BP);
        verify_request_set(CNT_BP);
        finish_test(errs);
    endtask

    task automatic test_shuffled_responses();
        int errs;
        cur_test = "shuffled_responses";
        errs = error_count;
        set_memory(2, 12, 1'b1);
        run_descriptor(32'h0000_7ff0, CNT_SHUFFLE, 1'b0);
        verify_lane_sums(32'h0000_7ff0, CNT_SHUFFLE);
        verify_request_set(CNT_SHUFFLE);
        finish_test(errs);
    endtask

    // Second descriptor after done clears the sums and reruns
    task automatic test_restart();
        int errs;
        cur_test = "restart";
        errs = error_count;
        set_memory(1, 1, 1'b0);
        run_descriptor(32'h0001_0000, CNT_FIRST, 1'b0);
        verify_lane_sums(32'h0001_0000, CNT_FIRST);
        run_descriptor(32'h0002_0040, CNT_SECOND, 1'b1);
        verify_lane_sums(32'h0002_0040, CNT_SECOND);
        verify_request_set(CNT_SECOND);
        finish_test(errs);
    endtask

    // Hard stop in case a wait never returns
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge ap_clk);
        $display("Watchdog expired after %0d cycles, tests did not complete", WATCHDOG_CYCLES);
        $display("Errors found");
        $finish;
    end

    initial begin
        areset_lanes     = 1'b1;
        descriptor_valid = 1'b0;
        descriptor_base  = '0;
        descriptor_count = '0;
        repeat (RESET_CYCLES) @(negedge ap_clk);
        areset_lanes = 1'b0;
        check_reset_values();
        test_single_descriptor();
        test_request_set();
        test_back_pressure();
        test_shuffled_responses();
        test_restart();
        $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
                 error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule : tb_bundle_lanes
